// File: Bender.yml
package:
  name: copperv

sources:
  - files:
      - hdl/copperv_isa_pkg.sv
      - hdl/copperv_bus_pkg.sv
      - hdl/idecoder.sv
      - hdl/register_file.sv
      - hdl/arith_logic_unit.sv
      - hdl/control_unit.sv
      - hdl/copperv.sv
  - target: test
    files:
      - verif/copperv_chk.sv
      - verif/copperv_tb.sv

// File: hdl/arith_logic_unit.sv
`timescale 1ns/100ps
`default_nettype none

module arith_logic_unit (
    input wire [copperv_isa_pkg::data_width-1:0] i_din1,
    input wire [copperv_isa_pkg::data_width-1:0] i_din2,
    input wire copperv_isa_pkg::alu_funct_e i_funct,
    output logic [copperv_isa_pkg::data_width-1:0] o_dout
);
    import copperv_isa_pkg::*;

    logic less;

    assign less = $signed(i_din1) < $signed(i_din2);  // Signed compare.

    always_comb begin
        case (i_funct)
            ALU_ADD: o_dout = i_din1 + i_din2;
            ALU_SUB: o_dout = i_din1 - i_din2;
            ALU_SLT: o_dout = {{(data_width-1){1'b0}}, less};
            ALU_XOR: o_dout = i_din1 ^ i_din2;
            ALU_OR: o_dout = i_din1 | i_din2;
            ALU_AND: o_dout = i_din1 & i_din2;
            ALU_PASS_B: o_dout = i_din2;  // LUI.
            default: o_dout = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input wire clk,
    input wire rst,
    input wire copperv_isa_pkg::inst_type_e i_inst_type,
    input wire i_raddr_done,
    input wire i_rdata_valid,
    input wire i_store_done,
    output logic o_fetch,
    output logic o_inst_load,
    output logic o_rd_en,
    output logic o_store_start,
    output logic o_pc_advance,
    output copperv_isa_pkg::rd_din_sel_e o_rd_din_sel
);
    import copperv_isa_pkg::*;

    typedef enum logic [1:0] {
        FETCH,
        WAIT_INST,
        EXECUTE,
        STORE
    } state_e;

    state_e state;
    state_e state_next;
    logic fetch_q;
    logic writes_rd;
    logic is_store;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= FETCH;
            fetch_q <= 1'b0;
        end else begin
            state <= state_next;
            fetch_q <= (state_next == FETCH);  // Valid follows the state.
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            FETCH: begin
                if (i_raddr_done) begin
                    state_next = WAIT_INST;
                end
            end
            WAIT_INST: begin
                if (i_rdata_valid) begin
                    state_next = EXECUTE;
                end
            end
            EXECUTE: begin
                state_next = is_store ? STORE : FETCH;
            end
            STORE: begin
                if (i_store_done) begin
                    state_next = FETCH;  // Both channels have handshaked.
                end
            end
            default: state_next = FETCH;
        endcase
    end

    assign writes_rd = (i_inst_type == TYPE_U) || (i_inst_type == TYPE_I) ||
                       (i_inst_type == TYPE_R);
    assign is_store = (i_inst_type == TYPE_S);

    assign o_fetch = fetch_q;
    assign o_inst_load = (state == WAIT_INST) && i_rdata_valid;
    assign o_rd_en = (state == EXECUTE) && writes_rd;
    assign o_store_start = (state == EXECUTE) && is_store;

    // NONE falls through here too, so unsupported words still retire.
    assign o_pc_advance = ((state == EXECUTE) && !is_store) ||
                          ((state == STORE) && i_store_done);

    assign o_rd_din_sel = (i_inst_type == TYPE_U) ? RD_DIN_IMM : RD_DIN_ALU;

endmodule

`default_nettype wire

// File: hdl/copperv.sv
`timescale 1ns/100ps
`default_nettype none

module copperv #(
    parameter logic [copperv_isa_pkg::pc_width-1:0] pc_init = '0
) (
    input wire clk,
    input wire rst,
    input wire i_i_raddr_ready,
    input wire i_i_rdata_valid,
    input wire [copperv_bus_pkg::bus_width-1:0] i_i_rdata,
    input wire i_d_waddr_ready,
    input wire i_d_wdata_ready,
    output logic o_i_raddr_valid,
    output logic [copperv_bus_pkg::bus_width-1:0] o_i_raddr,
    output logic o_i_rdata_ready,
    output logic o_d_waddr_valid,
    output logic [copperv_bus_pkg::bus_width-1:0] o_d_waddr,
    output logic o_d_wdata_valid,
    output logic [copperv_bus_pkg::bus_width-1:0] o_d_wdata
);
    import copperv_isa_pkg::*;
    import copperv_bus_pkg::*;

    logic [pc_width-1:0] pc;
    logic [inst_width-1:0] inst;
    decoded_t dec;
    logic [data_width-1:0] rs1_dout;
    logic [data_width-1:0] rs2_dout;
    logic [data_width-1:0] alu_din2;
    logic [data_width-1:0] alu_dout;
    logic [data_width-1:0] rd_din;
    store_req_t store_req;
    logic waddr_valid;
    logic wdata_valid;
    logic fetch;
    logic inst_load;
    logic rd_en;
    logic store_start;
    logic pc_advance;
    rd_din_sel_e rd_din_sel;
    logic raddr_done;
    logic store_done;

    assign o_i_raddr_valid = fetch;
    assign o_i_raddr = pc;
    assign o_i_rdata_ready = 1'b1;
    assign raddr_done = fetch && i_i_raddr_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= pc_init;
        end else if (pc_advance) begin
            pc <= pc + pc_width'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (inst_load) begin
            inst <= i_i_rdata;
        end
    end

    idecoder idec (
        .i_inst(inst),
        .o_dec(dec)
    );

    assign alu_din2 = (dec.inst_type == TYPE_R) ? rs2_dout : dec.imm;
    assign rd_din = (rd_din_sel == RD_DIN_IMM) ? dec.imm : alu_dout;

    register_file regfile (
        .clk(clk),
        .i_rd_en(rd_en),
        .i_rd(dec.rd),
        .i_rs1(dec.rs1),
        .i_rs2(dec.rs2),
        .i_rd_din(rd_din),
        .o_rs1_dout(rs1_dout),
        .o_rs2_dout(rs2_dout)
    );

    arith_logic_unit alu (
        .i_din1(rs1_dout),
        .i_din2(alu_din2),
        .i_funct(dec.alu_funct),
        .o_dout(alu_dout)
    );

    // Store address comes from the ALU add of rs1 and the S immediate.
    always_ff @(posedge clk) begin
        if (store_start) begin
            store_req.addr <= alu_dout;
            store_req.data <= rs2_dout;
        end
    end

    // Each valid falls after its own handshake.
    always_ff @(posedge clk) begin
        if (!rst) begin
            waddr_valid <= 1'b0;
            wdata_valid <= 1'b0;
        end else if (store_start) begin
            waddr_valid <= 1'b1;
            wdata_valid <= 1'b1;
        end else begin
            if (waddr_valid && i_d_waddr_ready) begin
                waddr_valid <= 1'b0;
            end
            if (wdata_valid && i_d_wdata_ready) begin
                wdata_valid <= 1'b0;
            end
        end
    end

    assign store_done = (waddr_valid || wdata_valid) &&
                        (!waddr_valid || i_d_waddr_ready) &&
                        (!wdata_valid || i_d_wdata_ready);  // Last one pending.

    assign o_d_waddr_valid = waddr_valid;
    assign o_d_wdata_valid = wdata_valid;
    assign o_d_waddr = store_req.addr;
    assign o_d_wdata = store_req.data;

    control_unit control (
        .clk(clk),
        .rst(rst),
        .i_inst_type(dec.inst_type),
        .i_raddr_done(raddr_done),
        .i_rdata_valid(i_i_rdata_valid),
        .i_store_done(store_done),
        .o_fetch(fetch),
        .o_inst_load(inst_load),
        .o_rd_en(rd_en),
        .o_store_start(store_start),
        .o_pc_advance(pc_advance),
        .o_rd_din_sel(rd_din_sel)
    );

endmodule

`default_nettype wire

// File: hdl/copperv_bus_pkg.sv
`default_nettype none

package copperv_bus_pkg;

    parameter int bus_width = 32;

    // One store as it leaves the core.
    typedef struct packed {
        logic [bus_width-1:0] addr;
        logic [bus_width-1:0] data;
    } store_req_t;

endpackage

`default_nettype wire

// File: hdl/copperv_isa_pkg.sv
`default_nettype none

package copperv_isa_pkg;

    parameter int data_width = 32;
    parameter int reg_width = 5;
    parameter int pc_width = 32;
    parameter int inst_width = 32;

    // Major opcodes of the supported subset.
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [2:0] {
        TYPE_U,
        TYPE_I,
        TYPE_R,
        TYPE_S,
        TYPE_NONE  // Retires as a no-op.
    } inst_type_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_funct_e;

    typedef enum logic [0:0] {
        RD_DIN_ALU,
        RD_DIN_IMM
    } rd_din_sel_e;

    typedef struct packed {
        opcode_e opcode;
        inst_type_e inst_type;
        alu_funct_e alu_funct;
        logic [reg_width-1:0] rd;
        logic [reg_width-1:0] rs1;
        logic [reg_width-1:0] rs2;
        logic [data_width-1:0] imm;  // Sign-extended per format.
    } decoded_t;

endpackage

`default_nettype wire

// File: hdl/idecoder.sv
`timescale 1ns/100ps
`default_nettype none

module idecoder (
    input wire [copperv_isa_pkg::inst_width-1:0] i_inst,
    output copperv_isa_pkg::decoded_t o_dec
);
    import copperv_isa_pkg::*;

    opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [data_width-1:0] imm_i;
    logic [data_width-1:0] imm_s;
    logic [data_width-1:0] imm_u;

    assign opcode = opcode_e'(i_inst[6:0]);
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_u = {i_inst[31:12], 12'b0};

    always_comb begin
        o_dec.opcode = opcode;
        o_dec.inst_type = TYPE_NONE;
        o_dec.alu_funct = ALU_ADD;
        o_dec.rd = i_inst[11:7];
        o_dec.rs1 = i_inst[19:15];
        o_dec.rs2 = i_inst[24:20];
        o_dec.imm = '0;
        case (opcode)
            OPC_LUI: begin
                o_dec.inst_type = TYPE_U;
                o_dec.alu_funct = ALU_PASS_B;
                o_dec.imm = imm_u;
            end
            OPC_OP_IMM: begin
                o_dec.imm = imm_i;
                o_dec.inst_type = TYPE_I;
                case (funct3)
                    3'b000: o_dec.alu_funct = ALU_ADD;
                    3'b010: o_dec.alu_funct = ALU_SLT;
                    3'b100: o_dec.alu_funct = ALU_XOR;
                    3'b110: o_dec.alu_funct = ALU_OR;
                    3'b111: o_dec.alu_funct = ALU_AND;
                    default: o_dec.inst_type = TYPE_NONE;  // Shifts and SLTIU.
                endcase
            end
            OPC_OP: begin
                o_dec.inst_type = TYPE_R;
                case ({funct7, funct3})
                    10'b0000000_000: o_dec.alu_funct = ALU_ADD;
                    10'b0100000_000: o_dec.alu_funct = ALU_SUB;
                    10'b0000000_010: o_dec.alu_funct = ALU_SLT;
                    10'b0000000_100: o_dec.alu_funct = ALU_XOR;
                    10'b0000000_110: o_dec.alu_funct = ALU_OR;
                    10'b0000000_111: o_dec.alu_funct = ALU_AND;
                    default: o_dec.inst_type = TYPE_NONE;
                endcase
            end
            OPC_STORE: begin
                o_dec.imm = imm_s;
                if (funct3 == 3'b010) begin
                    o_dec.inst_type = TYPE_S;  // Word stores only.
                end
            end
            default: o_dec.inst_type = TYPE_NONE;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input wire clk,
    input wire i_rd_en,
    input wire [copperv_isa_pkg::reg_width-1:0] i_rd,
    input wire [copperv_isa_pkg::reg_width-1:0] i_rs1,
    input wire [copperv_isa_pkg::reg_width-1:0] i_rs2,
    input wire [copperv_isa_pkg::data_width-1:0] i_rd_din,
    output logic [copperv_isa_pkg::data_width-1:0] o_rs1_dout,
    output logic [copperv_isa_pkg::data_width-1:0] o_rs2_dout
);
    import copperv_isa_pkg::*;

    logic [data_width-1:0] regs [2**reg_width];

    always_ff @(posedge clk) begin
        if (i_rd_en && (i_rd != '0)) begin
            regs[i_rd] <= i_rd_din;  // x0 is never written.
        end
    end

    // Index 0 reads as zero.
    assign o_rs1_dout = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_dout = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// File: src.f
hdl/copperv_isa_pkg.sv
hdl/copperv_bus_pkg.sv
hdl/idecoder.sv
hdl/register_file.sv
hdl/arith_logic_unit.sv
hdl/control_unit.sv
hdl/copperv.sv
verif/copperv_chk.sv
verif/copperv_tb.sv

// File: verif/copperv_chk.sv
`timescale 1ns/100ps
`default_nettype none

module copperv_chk (
    input wire clk,
    input wire rst,
    input wire i_raddr_valid,
    input wire [copperv_bus_pkg::bus_width-1:0] i_raddr,
    input wire i_raddr_ready,
    input wire i_waddr_valid,
    input wire [copperv_bus_pkg::bus_width-1:0] i_waddr,
    input wire i_waddr_ready,
    input wire i_wdata_valid,
    input wire [copperv_bus_pkg::bus_width-1:0] i_wdata,
    input wire i_wdata_ready
);

    raddr_held: assert property (@(posedge clk) disable iff (!rst)
        i_raddr_valid && !i_raddr_ready |=> i_raddr_valid && $stable(i_raddr))
        else $error("Fetch valid or address changed before its handshake");

    waddr_held: assert property (@(posedge clk) disable iff (!rst)
        i_waddr_valid && !i_waddr_ready |=> i_waddr_valid && $stable(i_waddr))
        else $error("Store address valid or value changed before its handshake");

    wdata_held: assert property (@(posedge clk) disable iff (!rst)
        i_wdata_valid && !i_wdata_ready |=> i_wdata_valid && $stable(i_wdata))
        else $error("Store data valid or value changed before its handshake");

    // Fetch and store never overlap.
    fetch_alone: assert property (@(posedge clk) disable iff (!rst)
        i_raddr_valid |-> !i_waddr_valid && !i_wdata_valid)
        else $error("Store valid high during a fetch request");

    reset_quiet: assert property (@(posedge clk)
        !rst |=> !i_raddr_valid && !i_waddr_valid && !i_wdata_valid)
        else $error("Bus valid high while in reset");

endmodule

bind copperv copperv_chk i_chk (
    .clk(clk),
    .rst(rst),
    .i_raddr_valid(o_i_raddr_valid),
    .i_raddr(o_i_raddr),
    .i_raddr_ready(i_i_raddr_ready),
    .i_waddr_valid(o_d_waddr_valid),
    .i_waddr(o_d_waddr),
    .i_waddr_ready(i_d_waddr_ready),
    .i_wdata_valid(o_d_wdata_valid),
    .i_wdata(o_d_wdata),
    .i_wdata_ready(i_d_wdata_ready)
);

`default_nettype wire

// File: verif/copperv_tb.sv
`timescale 1ns/100ps
`default_nettype none

module copperv_tb;
    import copperv_bus_pkg::*;

    localparam logic [31:0] pc_init = 32'h0;
    localparam int n_alu = 40;
    localparam int n_inst = 8 + n_alu + 8;
    localparam int mem_depth = 64;
    localparam int timeout_cycles = n_inst * 12 + 100;
    localparam logic [2:0] f3_tab [5] = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};

    logic clk;
    logic rst;
    logic raddr_ready;
    logic rdata_valid;
    logic [bus_width-1:0] rdata;
    logic waddr_ready;
    logic wdata_ready;
    wire raddr_valid;
    wire [bus_width-1:0] raddr;
    wire rdata_ready;
    wire waddr_valid;
    wire [bus_width-1:0] waddr;
    wire wdata_valid;
    wire [bus_width-1:0] wdata;

    logic [31:0] imem [mem_depth];
    logic [31:0] lfsr;
    store_req_t exp_stores[$];
    store_req_t got_stores[$];
    store_req_t got;
    int errors = 0;
    int n_checked = 0;
    int cycles = 0;
    int raddr_wait;
    int data_wait;
    int waddr_wait;
    int wdata_wait;
    bit prog_done = 0;
    bit raddr_xfer = 0;
    bit data_pending = 0;
    bit waddr_xfer = 0;
    bit wdata_xfer = 0;
    bit have_addr = 0;
    bit have_data = 0;
    logic [31:0] fetch_addr;
    logic [31:0] next_pc = pc_init;

    copperv #(
        .pc_init(pc_init)
    ) i_dut (
        .clk(clk),
        .rst(rst),
        .i_i_raddr_ready(raddr_ready),
        .i_i_rdata_valid(rdata_valid),
        .i_i_rdata(rdata),
        .i_d_waddr_ready(waddr_ready),
        .i_d_wdata_ready(wdata_ready),
        .o_i_raddr_valid(raddr_valid),
        .o_i_raddr(raddr),
        .o_i_rdata_ready(rdata_ready),
        .o_d_waddr_valid(waddr_valid),
        .o_d_waddr(waddr),
        .o_d_wdata_valid(wdata_valid),
        .o_d_wdata(wdata)
    );

    always #2 clk = ~clk;

    // Galois LFSR, one step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic build_program();
        int op;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [11:0] imm;
        logic [4:0] base;
        for (int a = 0; a < mem_depth; a++) begin
            imem[a] = {a[24:0], 7'h7f};  // Opcode outside the subset.
        end
        for (int r = 0; r < 8; r++) begin
            imem[r] = {20'(rand_bits(20)), 5'((r + 1) % 8), 7'b0110111};  // x1..x7, then x0.
        end
        for (int n = 0; n < n_alu; n++) begin
            op = rand_bits(4) % 12;
            rd = 5'(rand_bits(3));
            rs1 = 5'(rand_bits(3));
            rs2 = 5'(rand_bits(3));
            imm = 12'(rand_bits(12));
            if (n == 13)
                imem[8 + n] = {7'b0, rs2, rs1, 3'b001, rd | 5'd1, 7'b0010011};  // SLLI.
            else if (n == 29)
                imem[8 + n] = {imm, rs1, 3'b010, rd | 5'd1, 7'b0000011};  // LW.
            else if (op < 5)
                imem[8 + n] = {imm, rs1, f3_tab[op], rd, 7'b0010011};
            else if (op < 10)
                imem[8 + n] = {7'b0, rs2, rs1, f3_tab[op - 5], rd, 7'b0110011};
            else if (op == 10)
                imem[8 + n] = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            else
                imem[8 + n] = {20'(rand_bits(20)), rd, 7'b0110111};
        end
        base = 5'(rand_bits(3) % 7 + 1);
        for (int s = 0; s < 8; s++) begin
            imm = 12'(s * 292 - 1024);  // One base, distinct signed offsets.
            imem[8 + n_alu + s] = {imm[11:5], 5'(s), base, 3'b010, imm[4:0], 7'b0100011};
        end
    endtask

    // Runs the program on a register model and queues the expected stores.
    function automatic int run_reference();
        logic [31:0] x [32];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [6:0] f7;
        logic [2:0] f3;
        logic wr;
        store_req_t st;
        for (int r = 0; r < 32; r++) begin
            x[r] = '0;
        end
        for (int i = 0; i < n_inst; i++) begin
            w = imem[i];
            f3 = w[14:12];
            f7 = w[31:25];
            a = x[w[19:15]];
            wr = 1'b0;
            res = '0;
            case (w[6:0])
                7'b0110111: begin
                    res = {w[31:12], 12'h000};
                    wr = 1'b1;
                end
                7'b0010011, 7'b0110011: begin
                    b = w[5] ? x[w[24:20]] : {{20{w[31]}}, w[31:20]};
                    wr = (f3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111}) &&
                         (!w[5] || f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b000));
                    case (f3)
                        3'b000: res = (w[5] && f7 == 7'h20) ? a - b : a + b;
                        3'b010: res = {31'b0, $signed(a) < $signed(b)};
                        3'b100: res = a ^ b;
                        3'b110: res = a | b;
                        default: res = a & b;
                    endcase
                end
                7'b0100011: begin
                    if (f3 == 3'b010) begin
                        st.addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                        st.data = x[w[24:20]];
                        exp_stores.push_back(st);
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0) x[w[11:7]] = res;
        end
        return exp_stores.size();
    endfunction

    task automatic serve_fetch();
        if (raddr_xfer) begin
            raddr_xfer = 1'b0;
            if (fetch_addr !== next_pc) begin
                $display("Error at %0t ns: o_i_raddr expected %h, got %h",
                         $time, next_pc, fetch_addr);
                errors++;
            end
            next_pc = fetch_addr + 32'd4;
            if (fetch_addr == pc_init + 4 * n_inst) prog_done = 1'b1;
            data_pending = 1'b1;
            data_wait = rand_bits(2);
        end
        rdata_valid = 1'b0;
        if (data_pending) begin
            if (data_wait == 0) begin
                rdata_valid = 1'b1;
                rdata = imem[fetch_addr[7:2]];
                data_pending = 1'b0;
                if (rdata_ready !== 1'b1) begin
                    $display("Error at %0t ns: o_i_rdata_ready expected 1, got %b",
                             $time, rdata_ready);
                    errors++;
                end
            end else begin
                data_wait--;
            end
        end
        raddr_ready = 1'b0;
        if (raddr_valid === 1'b1) begin
            if (raddr_wait == 0) begin
                raddr_ready = 1'b1;
                raddr_xfer = 1'b1;  // Transfer happens at the next edge.
                fetch_addr = raddr;
                raddr_wait = rand_bits(2);
            end else begin
                raddr_wait--;
            end
        end
    endtask

    task automatic serve_stores();
        have_addr = have_addr | waddr_xfer;
        have_data = have_data | wdata_xfer;
        waddr_xfer = 1'b0;
        wdata_xfer = 1'b0;
        if (have_addr && have_data) begin
            got_stores.push_back(got);
            have_addr = 1'b0;
            have_data = 1'b0;
        end
        waddr_ready = 1'b0;
        if (waddr_valid === 1'b1) begin
            if (waddr_wait == 0) begin
                waddr_ready = 1'b1;
                waddr_xfer = 1'b1;
                got.addr = waddr;
                waddr_wait = rand_bits(2);
            end else begin
                waddr_wait--;
            end
        end
        wdata_ready = 1'b0;
        if (wdata_valid === 1'b1) begin
            if (wdata_wait == 0) begin
                wdata_ready = 1'b1;
                wdata_xfer = 1'b1;
                got.data = wdata;
                wdata_wait = rand_bits(2);
            end else begin
                wdata_wait--;
            end
        end
    endtask

    always @(posedge clk) begin
        #0.5;
        serve_fetch();
        serve_stores();
    end

    always @(negedge clk) begin
        store_req_t cur;
        store_req_t exp;
        while (got_stores.size() > 0) begin
            cur = got_stores.pop_front();
            if (n_checked >= exp_stores.size()) begin
                $display("Unexpected store of %h to address %h at %0t ns",
                         cur.data, cur.addr, $time);
                errors++;
            end else begin
                exp = exp_stores[n_checked];
                if (cur.addr !== exp.addr) begin
                    $display("Error at %0t ns: o_d_waddr expected %h, got %h",
                             $time, exp.addr, cur.addr);
                    errors++;
                end
                if (cur.data !== exp.data) begin
                    $display("Error at %0t ns: o_d_wdata expected %h, got %h",
                             $time, exp.data, cur.data);
                    errors++;
                end
            end
            n_checked++;
        end
    end

    initial begin
        int n_exp;
        clk = 1'b0;
        rst = 1'b0;
        raddr_ready = 1'b0;
        rdata_valid = 1'b0;
        rdata = '0;
        waddr_ready = 1'b0;
        wdata_ready = 1'b0;
        lfsr = 32'h9118_0095;
        build_program();
        n_exp = run_reference();
        raddr_wait = rand_bits(2);
        waddr_wait = rand_bits(2);
        wdata_wait = rand_bits(2);
        repeat (4) @(posedge clk);
        #0.5;
        rst = 1'b1;
        while (!prog_done && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);
        if (!prog_done) begin
            $display("Timeout: the program did not finish within %0d cycles", timeout_cycles);
            errors++;
        end
        if (n_checked != n_exp) begin
            $display("Wrong number of stores: expected %0d, saw %0d", n_exp, n_checked);
            errors++;
        end
        $display("Run ended after %0d cycles: %0d errors, %0d of %0d stores checked",
                 cycles, errors, n_checked, n_exp);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
